//--- scroll_render.f
+incdir+hdl
hdl/scroll_pkg.sv
hdl/line_ram.sv
hdl/tile_line_fetch.sv
hdl/layer_sequencer.sv
hdl/line_buffer_bank.sv
hdl/scroll_render.sv
test/mem_models.sv
test/scroll_render_tb.sv

//--- test/scroll_render_tb.sv
// Testbench for the scroll renderer, one line per start edge
// Expected pixels come from the reference function in the memory models
// Line content shown is tracked per swap, aborted renders are only checked for blanking
`timescale 1ns/10ps
`default_nettype none

`include "scroll_defines.svh"

module scroll_render_tb;

    logic        clk;
    logic        rst;
    logic [8:0]  vrender;
    logic [8:0]  hdump;
    logic        preVB;
    logic        start;
    logic [2:0]  gfx_en;
    logic [15:0] hp_r [3];
    logic [15:0] vp_r [3];
    logic [15:0] vb_r [3];
    logic [15:0] bank_offset;
    logic [15:0] bank_mask;
    logic [17:1] vram_addr;
    logic [15:0] vram_data;
    logic        vram_ok;
    logic        vram_cs;
    logic [19:0] rom_addr;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic        rom_cs;
    logic [10:0] scr1_pxl;
    logic [10:0] scr2_pxl;
    logic [10:0] scr3_pxl;
    logic        line_done;

    int          errors;
    int          done_cnt;
    int          exp_done;
    logic        timed_out;
    logic        started;
    logic        seen_done;
    logic        rend_active;  // Render running, its line_done still due
    logic        rend_ok;
    logic [8:0]  rend_v;
    logic        disp_ok;      // Read half holds a complete render
    logic [8:0]  disp_v;
    logic [8:0]  hd_q1;
    logic [8:0]  hd_q2;        // hdump that the outputs now show
    logic [10:0] exp_w [3];

    scroll_render i_scroll_render (
        .clk (clk), .rst (rst), .vrender (vrender), .hdump (hdump), .preVB (preVB),
        .vram1_base (vb_r[0]), .vram2_base (vb_r[1]), .vram3_base (vb_r[2]),
        .hpos1 (hp_r[0]), .hpos2 (hp_r[1]), .hpos3 (hp_r[2]),
        .vpos1 (vp_r[0]), .vpos2 (vp_r[1]), .vpos3 (vp_r[2]),
        .bank_offset (bank_offset), .bank_mask (bank_mask), .start (start),
        .gfx_en (gfx_en), .vram_addr (vram_addr), .vram_data (vram_data),
        .vram_ok (vram_ok), .vram_cs (vram_cs), .rom_addr (rom_addr),
        .rom_data (rom_data), .rom_ok (rom_ok), .rom_cs (rom_cs),
        .scr1_pxl (scr1_pxl), .scr2_pxl (scr2_pxl), .scr3_pxl (scr3_pxl),
        .line_done (line_done)
    );

    mem_models i_mem_models (
        .clk (clk), .rst (rst), .vram_addr (vram_addr), .vram_cs (vram_cs),
        .vram_data (vram_data), .vram_ok (vram_ok), .rom_addr (rom_addr),
        .rom_cs (rom_cs), .rom_data (rom_data), .rom_ok (rom_ok)
    );

    function automatic bit in_window(input logic [8:0] h);
        return h >= `SCR_ACT_START && h <= `SCR_ACT_END;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] e, input logic [31:0] a);
        errors++;
        $display("FAIL at %0t: %s expected %h got %h", $time, sig, e, a);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            hd_q1 <= 9'd0;
            hd_q2 <= 9'd0;
        end else begin
            hd_q1 <= hdump;
            hd_q2 <= hd_q1;
        end
    end

    always @(posedge clk) begin
        if (!rst && line_done) begin
            done_cnt    <= done_cnt + 1;
            seen_done   <= 1'b1;
            rend_active <= 1'b0;
            rend_ok     <= 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            exp_w[i] = gfx_en[i] ? i_mem_models.ref_pxl(i, disp_v, hd_q2, hp_r[i], vp_r[i],
                                                         vb_r[i], bank_offset, bank_mask)
                                 : `SCR_BLANK;
        end
    end

    a_pre_blank: assert property (@(posedge clk) disable iff (rst) !seen_done |->
        scr1_pxl == `SCR_BLANK && scr2_pxl == `SCR_BLANK && scr3_pxl == `SCR_BLANK)
        else report_problem("pixel output not blank before the first rendered line");
    a_idle_cs: assert property (@(posedge clk) disable iff (rst) !started |-> !vram_cs && !rom_cs)
        else report_problem("memory cs raised before any start edge");
    a_out_blank: assert property (@(posedge clk) disable iff (rst) !in_window(hd_q2) |->
        scr1_pxl == `SCR_BLANK && scr2_pxl == `SCR_BLANK && scr3_pxl == `SCR_BLANK)
        else report_problem("pixel output not blank outside the active window");
    a_scr1: assert property (@(posedge clk) disable iff (rst)
        disp_ok && in_window(hd_q2) |-> scr1_pxl == exp_w[0])
        else report_mismatch("scr1_pxl", $sampled(exp_w[0]), $sampled(scr1_pxl));
    a_scr2: assert property (@(posedge clk) disable iff (rst)
        disp_ok && in_window(hd_q2) |-> scr2_pxl == exp_w[1])
        else report_mismatch("scr2_pxl", $sampled(exp_w[1]), $sampled(scr2_pxl));
    a_scr3: assert property (@(posedge clk) disable iff (rst)
        disp_ok && in_window(hd_q2) |-> scr3_pxl == exp_w[2])
        else report_mismatch("scr3_pxl", $sampled(exp_w[2]), $sampled(scr3_pxl));

    // cs and address hold until ok unless a start edge aborts the render
    a_vram_hold: assert property (@(posedge clk) disable iff (rst)
        vram_cs && !vram_ok && !($rose(start) && !preVB) |=> vram_cs && $stable(vram_addr))
        else report_problem("VRAM request changed before ok");
    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok && !($rose(start) && !preVB) |=> rom_cs && $stable(rom_addr))
        else report_problem("ROM request changed before ok");
    a_vram_drop: assert property (@(posedge clk) disable iff (rst) vram_ok |=> !vram_cs)
        else report_problem("vram_cs still high the cycle after ok");
    a_rom_drop: assert property (@(posedge clk) disable iff (rst) rom_ok |=> !rom_cs)
        else report_problem("rom_cs still high the cycle after ok");
    a_cs_excl: assert property (@(posedge clk) disable iff (rst) !(vram_cs && rom_cs))
        else report_problem("vram_cs and rom_cs high together");
    a_done_once: assert property (@(posedge clk) disable iff (rst) line_done |-> rend_active)
        else report_problem("line_done without a pending render");

    task automatic run_line(input logic [8:0] v, input bit pre, input bit sweep,
                            input bit wait_done);
        int start_cnt;
        int cnt;
        if (timed_out) begin
            return;
        end
        @(negedge clk);
        vrender = v;
        preVB   = pre;
        hdump   = 9'd0;
        start   = 1'b1;
        started = 1'b1;
        if (!pre) begin     // Halves swap, new render begins
            disp_ok     = rend_ok;
            disp_v      = rend_v;
            rend_ok     = 1'b0;
            rend_v      = v;
            rend_active = 1'b1;
        end
        start_cnt = done_cnt;
        repeat (2) @(negedge clk);
        start = 1'b0;
        preVB = 1'b0;
        if (sweep) begin
            for (int h = 0; h < 512; h++) begin
                hdump = 9'(h);
                @(negedge clk);
            end
            hdump = 9'd0;
        end
        if (wait_done) begin
            cnt = 0;
            while (done_cnt == start_cnt && cnt < 20000) begin
                @(negedge clk);
                cnt++;
            end
            if (done_cnt == start_cnt) begin
                report_problem($sformatf("timeout waiting for line_done on line %0d", v));
                timed_out = 1'b1;
            end else begin
                exp_done++;
                repeat (4) @(negedge clk);
            end
        end
    endtask

    initial begin
        errors      = 0;
        done_cnt    = 0;
        exp_done    = 0;
        timed_out   = 1'b0;
        started     = 1'b0;
        seen_done   = 1'b0;
        rend_active = 1'b0;
        rend_ok     = 1'b0;
        rend_v      = 9'd0;
        disp_ok     = 1'b0;
        disp_v      = 9'd0;
        rst         = 1'b1;
        vrender     = 9'd0;
        hdump       = 9'd0;
        preVB       = 1'b0;
        start       = 1'b0;
        gfx_en      = 3'b111;
        hp_r        = '{16'h0013, 16'h0125, 16'h0347};
        vp_r        = '{16'h0007, 16'h0021, 16'h01f3};
        vb_r        = '{16'h1000, 16'h3000, 16'h5000};
        bank_offset = 16'h0340;
        bank_mask   = 16'h0fff;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);

        run_line(9'd0, 1'b0, 1'b0, 1'b1);   // First render, nothing to show yet
        run_line(9'd1, 1'b0, 1'b1, 1'b1);
        gfx_en = 3'b101;                    // Layer 2 off
        run_line(9'd2, 1'b0, 1'b1, 1'b1);
        gfx_en = 3'b111;
        run_line(9'd3, 1'b1, 1'b1, 1'b0);   // preVB, previous pixels repeat
        run_line(9'd4, 1'b0, 1'b1, 1'b0);   // Aborted by the next start edge
        run_line(9'd5, 1'b0, 1'b1, 1'b1);
        run_line(9'd6, 1'b0, 1'b1, 1'b1);
        gfx_en = 3'b011;
        run_line(9'd7, 1'b0, 1'b1, 1'b1);
        repeat (10) @(negedge clk);

        if (done_cnt != exp_done) begin
            report_problem("line_done count differs from completed lines");
        end
        $display("Checks done: %0d errors, %0d line_done pulses, %0d expected",
                 errors, done_cnt, exp_done);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/mem_models.sv
// VRAM and ROM models for the scroll renderer testbench
// Data is a fixed pattern of the whole address, ok comes 1 to 4 cycles after cs
// A request dropped before ok is forgotten
`timescale 1ns/10ps
`default_nettype none

module mem_models (
    input  logic        clk,
    input  logic        rst,
    input  logic [17:1] vram_addr,
    input  logic        vram_cs,
    output logic [15:0] vram_data,
    output logic        vram_ok,
    input  logic [19:0] rom_addr,
    input  logic        rom_cs,
    output logic [31:0] rom_data,
    output logic        rom_ok
);

    logic [31:0] seed;
    logic [2:0]  v_cnt;
    logic [2:0]  r_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] vram_pattern(input logic [16:0] a);
        return 16'(a * 17'h1b3 + (a >> 5));
    endfunction

    function automatic logic [31:0] rom_pattern(input logic [19:0] a);
        return (32'(a) * 32'h9e3779b1) ^ {a, 12'h5a5};
    endfunction

    // Expected pixel for layer lyr (0 to 2) at buffer address a of line vr
    function automatic logic [10:0] ref_pxl(input int lyr, input logic [8:0] vr,
                                            input logic [8:0] a, input logic [15:0] hp,
                                            input logic [15:0] vp, input logic [15:0] base,
                                            input logic [15:0] off, input logic [15:0] mask);
        logic [10:0] x;
        logic [10:0] y;
        logic [5:0]  row;
        logic [5:0]  col;
        logic [16:0] ca;
        logic [15:0] code;
        logic [15:0] attr;
        logic [15:0] cb;
        logic [19:0] ra;
        logic [31:0] w;
        x    = hp[10:0] + {2'd0, a};    // Wraps at 2048, plane size sets the usable bits
        y    = vp[10:0] + {2'd0, vr};
        row  = 6'(y >> (3 + lyr));
        col  = 6'(x >> (3 + lyr));
        ca   = {1'b0, base} + {4'd0, row, col, 1'b0};
        code = vram_pattern(ca);
        attr = vram_pattern(ca + 17'd1);
        cb   = (code & mask) | off;
        case (lyr)
            0:       ra = 20'({cb, y[2:0]});
            1:       ra = 20'({cb, y[3:0], x[3]});
            default: ra = 20'({cb, y[4:0], x[4:3]});
        endcase
        w = rom_pattern(ra);
        return {2'(lyr + 1), attr[4:0], 4'(w >> (28 - 4 * x[2:0]))};
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            seed    <= 32'ha267;
            v_cnt   <= 3'd0;
            r_cnt   <= 3'd0;
            vram_ok <= 1'b0;
            rom_ok  <= 1'b0;
        end else begin
            vram_ok <= 1'b0;
            rom_ok  <= 1'b0;
            if (!vram_cs) begin
                v_cnt <= 3'd0;
            end else if (!vram_ok) begin
                if (v_cnt == 3'd0) begin
                    seed  <= lcg_next(seed);
                    v_cnt <= 3'd1 + 3'(seed[17:16]);
                end else if (v_cnt == 3'd1) begin
                    vram_ok   <= 1'b1;
                    vram_data <= vram_pattern(vram_addr);
                    v_cnt     <= 3'd0;
                end else begin
                    v_cnt <= v_cnt - 3'd1;
                end
            end
            if (!rom_cs) begin
                r_cnt <= 3'd0;
            end else if (!rom_ok) begin
                if (r_cnt == 3'd0) begin
                    seed  <= lcg_next(seed);
                    r_cnt <= 3'd1 + 3'(seed[21:20]);
                end else if (r_cnt == 3'd1) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_pattern(rom_addr);
                    r_cnt    <= 3'd0;
                end else begin
                    r_cnt <= r_cnt - 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/scroll_render.sv
// Scroll layer renderer, three planes with 8x8, 16x16 and 32x32 tiles
// Renders the next line on each start edge, shows the previous one by hdump
// Single fixed ROM bank scheme through bank_offset and bank_mask
`timescale 1ns/10ps
`default_nettype none

`include "scroll_defines.svh"

module scroll_render (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [8:0]             vrender,
    input  logic [`SCR_LINE_W-1:0] hdump,
    input  logic                   preVB,
    input  logic [15:0]            vram1_base,
    input  logic [15:0]            vram2_base,
    input  logic [15:0]            vram3_base,
    input  logic [15:0]            hpos1,
    input  logic [15:0]            hpos2,
    input  logic [15:0]            hpos3,
    input  logic [15:0]            vpos1,
    input  logic [15:0]            vpos2,
    input  logic [15:0]            vpos3,
    input  logic [15:0]            bank_offset,
    input  logic [15:0]            bank_mask,
    input  logic                   start,
    input  logic [2:0]             gfx_en,
    output logic [17:1]            vram_addr,
    input  logic [15:0]            vram_data,
    input  logic                   vram_ok,
    output logic                   vram_cs,
    output logic [19:0]            rom_addr,
    input  logic [31:0]            rom_data,
    input  logic                   rom_ok,
    output logic                   rom_cs,
    output scroll_pkg::pxl_t       scr1_pxl,
    output scroll_pkg::pxl_t       scr2_pxl,
    output scroll_pkg::pxl_t       scr3_pxl,
    output logic                   line_done
);

    import scroll_pkg::*;

    layer_e                 layer;
    logic [15:0]            hpos;
    logic [15:0]            vpos;
    logic [15:0]            vram_base;
    logic                   sub_start;
    logic                   sub_done;
    logic                   abort;
    logic                   rd_half;
    logic                   wr_half;
    logic [`SCR_LINE_W-1:0] buf_addr;
    pxl_t                   buf_data;
    logic                   buf_wr;

    layer_sequencer i_layer_sequencer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .preVB      (preVB),
        .vram1_base (vram1_base),
        .vram2_base (vram2_base),
        .vram3_base (vram3_base),
        .hpos1      (hpos1),
        .hpos2      (hpos2),
        .hpos3      (hpos3),
        .vpos1      (vpos1),
        .vpos2      (vpos2),
        .vpos3      (vpos3),
        .sub_done   (sub_done),
        .sub_start  (sub_start),
        .abort      (abort),
        .layer      (layer),
        .hpos       (hpos),
        .vpos       (vpos),
        .vram_base  (vram_base),
        .rd_half    (rd_half),
        .wr_half    (wr_half),
        .line_done  (line_done)
    );

    tile_line_fetch i_tile_line_fetch (
        .clk         (clk),
        .rst         (rst),
        .vrender     (vrender),
        .layer       (layer),
        .hpos        (hpos),
        .vpos        (vpos),
        .vram_base   (vram_base),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .start       (sub_start),
        .abort       (abort),
        .done        (sub_done),
        .vram_addr   (vram_addr),
        .vram_data   (vram_data),
        .vram_ok     (vram_ok),
        .vram_cs     (vram_cs),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .rom_cs      (rom_cs),
        .buf_addr    (buf_addr),
        .buf_data    (buf_data),
        .buf_wr      (buf_wr)
    );

    line_buffer_bank i_line_buffer_bank (
        .clk      (clk),
        .rst      (rst),
        .layer    (layer),
        .buf_addr (buf_addr),
        .buf_data (buf_data),
        .buf_wr   (buf_wr),
        .wr_half  (wr_half),
        .rd_half  (rd_half),
        .hdump    (hdump),
        .gfx_en   (gfx_en),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .scr3_pxl (scr3_pxl)
    );

endmodule

`default_nettype wire

//--- hdl/line_buffer_bank.sv
// Ping-pong line buffers for the three planes, plus the output registers
// Pixel for a given hdump appears two cycles later
`timescale 1ns/10ps
`default_nettype none

`include "scroll_defines.svh"

module line_buffer_bank (
    input  logic                   clk,
    input  logic                   rst,
    input  scroll_pkg::layer_e     layer,
    input  logic [`SCR_LINE_W-1:0] buf_addr,
    input  scroll_pkg::pxl_t       buf_data,
    input  logic                   buf_wr,
    input  logic                   wr_half,
    input  logic                   rd_half,
    input  logic [`SCR_LINE_W-1:0] hdump,
    input  logic [2:0]             gfx_en,
    output scroll_pkg::pxl_t       scr1_pxl,
    output scroll_pkg::pxl_t       scr2_pxl,
    output scroll_pkg::pxl_t       scr3_pxl
);

    import scroll_pkg::*;

    pxl_t ram_q [3];
    pxl_t pxl_r [3];
    logic act_d;    // Window flag aligned with RAM output

    for (genvar g = 0; g < 3; g++) begin : g_line
        line_ram #(
            .data_w (`SCR_PXL_W),
            .addr_w (`SCR_LINE_W + 1)
        ) i_line_ram (
            .clk   (clk),
            .we    (buf_wr && layer == layer_e'(g)),
            .waddr ({wr_half, buf_addr}),
            .wdata (buf_data),
            .raddr ({rd_half, hdump}),
            .q     (ram_q[g])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            act_d <= 1'b0;
            for (int i = 0; i < 3; i++) begin
                pxl_r[i] <= `SCR_BLANK;
            end
        end else begin
            act_d <= hdump >= `SCR_ACT_START && hdump <= `SCR_ACT_END;
            for (int i = 0; i < 3; i++) begin
                pxl_r[i] <= act_d && gfx_en[i] ? ram_q[i] : `SCR_BLANK;
            end
        end
    end

    assign scr1_pxl = pxl_r[0];
    assign scr2_pxl = pxl_r[1];
    assign scr3_pxl = pxl_r[2];

endmodule

`default_nettype wire

//--- hdl/layer_sequencer.sv
// Steps the fetch engine through layers 1 to 3 after each start edge
// Edges during preVB are ignored, so the halves do not swap then
`timescale 1ns/10ps
`default_nettype none

module layer_sequencer (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               preVB,
    input  logic [15:0]        vram1_base,
    input  logic [15:0]        vram2_base,
    input  logic [15:0]        vram3_base,
    input  logic [15:0]        hpos1,
    input  logic [15:0]        hpos2,
    input  logic [15:0]        hpos3,
    input  logic [15:0]        vpos1,
    input  logic [15:0]        vpos2,
    input  logic [15:0]        vpos3,
    input  logic               sub_done,
    output logic               sub_start,
    output logic               abort,
    output scroll_pkg::layer_e layer,
    output logic [15:0]        hpos,
    output logic [15:0]        vpos,
    output logic [15:0]        vram_base,
    output logic               rd_half,
    output logic               wr_half,
    output logic               line_done
);

    import scroll_pkg::*;

    logic last_start;
    logic go;       // Next sub_start pending
    logic busy;     // Engine rendering a layer
    logic step;

    assign abort = start && !last_start && !preVB;
    assign step  = sub_done && busy && !abort;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_start <= 1'b0;
            go         <= 1'b0;
            busy       <= 1'b0;
            sub_start  <= 1'b0;
            line_done  <= 1'b0;
            layer      <= LAYER1;
            rd_half    <= 1'b0;
            wr_half    <= 1'b1;
        end else begin
            last_start <= start;
            sub_start  <= go && !abort;
            go         <= 1'b0;
            line_done  <= 1'b0;
            if (sub_start) begin
                busy <= 1'b1;
            end else if (sub_done) begin
                busy <= 1'b0;
            end
            if (abort) begin
                rd_half <= ~rd_half;
                wr_half <= ~wr_half;
                layer   <= LAYER1;
                go      <= 1'b1;
                busy    <= 1'b0;    // Old render is dropped
            end else if (step) begin
                case (layer)
                    LAYER1: begin
                        layer <= LAYER2;
                        go    <= 1'b1;
                    end
                    LAYER2: begin
                        layer <= LAYER3;
                        go    <= 1'b1;
                    end
                    default: line_done <= 1'b1;
                endcase
            end
        end
    end

    // Register set of the layer about to start
    always_ff @(posedge clk) begin
        if (abort) begin
            hpos      <= hpos1;
            vpos      <= vpos1;
            vram_base <= vram1_base;
        end else if (step && layer == LAYER1) begin
            hpos      <= hpos2;
            vpos      <= vpos2;
            vram_base <= vram2_base;
        end else if (step && layer == LAYER2) begin
            hpos      <= hpos3;
            vpos      <= vpos3;
            vram_base <= vram3_base;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (rst) sub_start |-> !busy);

endmodule

`default_nettype wire

//--- hdl/tile_line_fetch.sv
// Renders one line of one scroll plane into the line buffer, 8 pixels per ROM word
// Memory requests hold address and cs until ok, then cs drops for one cycle
// Plane is 64x64 tiles, x and y wrap at the plane size. No flips, no row scroll
`timescale 1ns/10ps
`default_nettype none

`include "scroll_defines.svh"

module tile_line_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [8:0]             vrender,
    input  scroll_pkg::layer_e     layer,
    input  logic [15:0]            hpos,
    input  logic [15:0]            vpos,
    input  logic [15:0]            vram_base,
    input  logic [15:0]            bank_offset,
    input  logic [15:0]            bank_mask,
    input  logic                   start,
    input  logic                   abort,
    output logic                   done,
    output logic [17:1]            vram_addr,
    input  logic [15:0]            vram_data,
    input  logic                   vram_ok,
    output logic                   vram_cs,
    output logic [19:0]            rom_addr,
    input  logic [31:0]            rom_data,
    input  logic                   rom_ok,
    output logic                   rom_cs,
    output logic [`SCR_LINE_W-1:0] buf_addr,
    output scroll_pkg::pxl_t       buf_data,
    output logic                   buf_wr
);

    import scroll_pkg::*;

    fetch_state_e state;
    logic [9:0]   pos;      // Buffer position, negative during the fine scroll lead-in
    logic [9:0]   pos_nxt;
    logic [2:0]   px_cnt;
    logic [15:0]  code;
    logic [15:0]  code_b;
    logic [4:0]   attr;
    logic [31:0]  pix;
    logic [8:0]   vr_l;     // Line being rendered, held for the whole layer
    logic [10:0]  x;
    logic [10:0]  x_nxt;
    logic [10:0]  y;
    logic [5:0]   t_row;
    logic [5:0]   t_col;
    logic [16:0]  map_addr;
    logic [1:0]   lyr_num;
    logic         bnd;      // Next group starts a new tile
    logic         in_range;
    logic         last;

    assign x        = hpos[10:0] + {pos[9], pos};
    assign x_nxt    = x + 11'd1;
    assign y        = 11'(vr_l) + vpos[10:0];
    assign pos_nxt  = pos + 10'd1;
    assign in_range = !pos[9] && (pos < 10'(`SCR_RENDER_W));
    assign last     = !pos_nxt[9] && (pos_nxt >= 10'(`SCR_RENDER_W));
    assign code_b   = (code & bank_mask) | bank_offset;
    assign lyr_num  = 2'(layer) + 2'd1;

    always_comb begin
        case (layer)
            LAYER2: begin
                t_row    = y[9:4];
                t_col    = x[9:4];
                rom_addr = 20'({code_b, y[3:0], x[3]});
                bnd      = !x_nxt[3];
            end
            LAYER3: begin
                t_row    = y[10:5];
                t_col    = x[10:5];
                rom_addr = 20'({code_b, y[4:0], x[4:3]});
                bnd      = x_nxt[4:3] == 2'd0;
            end
            default: begin  // 8x8 tiles, one group per tile row
                t_row    = y[8:3];
                t_col    = x[8:3];
                rom_addr = 20'({code_b, y[2:0]});
                bnd      = 1'b1;
            end
        endcase
    end

    // Two VRAM words per map entry
    assign map_addr  = {1'b0, vram_base} + {4'd0, t_row, t_col, 1'b0};
    assign vram_addr = map_addr + 17'(state == MAP_ATTR);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            pos     <= 10'd0;
            px_cnt  <= 3'd0;
            vram_cs <= 1'b0;
            rom_cs  <= 1'b0;
            buf_wr  <= 1'b0;
            done    <= 1'b0;
        end else begin
            buf_wr <= 1'b0;
            done   <= 1'b0;
            if (abort) begin
                state   <= IDLE;
                vram_cs <= 1'b0;
                rom_cs  <= 1'b0;
            end else begin
                case (state)
                    IDLE: begin
                        if (start) begin
                            pos   <= 10'd0 - {7'd0, hpos[2:0]};
                            state <= MAP_CODE;
                        end
                    end
                    MAP_CODE, MAP_ATTR: begin
                        if (!vram_cs) begin
                            vram_cs <= 1'b1;
                        end else if (vram_ok) begin
                            vram_cs <= 1'b0;
                            state   <= state == MAP_CODE ? MAP_ATTR : ROM_RD;
                        end
                    end
                    ROM_RD: begin
                        if (!rom_cs) begin
                            rom_cs <= 1'b1;
                        end else if (rom_ok) begin
                            rom_cs <= 1'b0;
                            px_cnt <= 3'd0;
                            state  <= WRITE_PX;
                        end
                    end
                    WRITE_PX: begin
                        buf_wr <= in_range;     // Lead-in pixels are dropped
                        pos    <= pos_nxt;
                        px_cnt <= px_cnt + 3'd1;
                        if (px_cnt == 3'd7) begin
                            if (last) begin
                                state <= DONE;
                            end else begin
                                state <= bnd ? MAP_CODE : ROM_RD;
                            end
                        end
                    end
                    DONE: begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            vr_l <= vrender;
        end
        if (state == MAP_CODE && vram_ok) begin
            code <= vram_data;
        end
        if (state == MAP_ATTR && vram_ok) begin
            attr <= vram_data[4:0];
        end
        if (state == ROM_RD && rom_ok) begin
            pix <= rom_data;
        end else if (state == WRITE_PX) begin
            pix <= pix << 4;    // Leftmost pixel sits in the top nibble
        end
        buf_addr <= pos[`SCR_LINE_W-1:0];
        buf_data <= {lyr_num, attr, pix[31:28]};
    end

    a_vram_hold: assert property (@(posedge clk) disable iff (rst)
        vram_cs && !vram_ok && !abort |=> vram_cs && $stable(vram_addr));

    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok && !abort |=> rom_cs && $stable(rom_addr));

    a_cs_excl: assert property (@(posedge clk) disable iff (rst) !(vram_cs && rom_cs));

endmodule

`default_nettype wire

//--- hdl/line_ram.sv
// Single clock dual-port RAM, one write port and one registered read port
// Reading the address being written returns the old contents
`timescale 1ns/10ps
`default_nettype none

module line_ram #(
    parameter int data_w = 11,
    parameter int addr_w = 10
) (
    input  logic              clk,
    input  logic              we,
    input  logic [addr_w-1:0] waddr,
    input  logic [data_w-1:0] wdata,
    input  logic [addr_w-1:0] raddr,
    output logic [data_w-1:0] q
);

    logic [data_w-1:0] mem [2**addr_w];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        q <= mem[raddr];    // One cycle read latency
    end

endmodule

`default_nettype wire

//--- hdl/scroll_pkg.sv
// Types shared by the scroll renderer blocks
// Pixel layout is {layer number, attribute[4:0], color[3:0]}
`default_nettype none

`include "scroll_defines.svh"

package scroll_pkg;

    // Tile size follows the layer, 8, 16 or 32 pixels
    typedef enum logic [1:0] {
        LAYER1 = 2'd0,
        LAYER2 = 2'd1,
        LAYER3 = 2'd2
    } layer_e;

    typedef enum logic [2:0] {
        IDLE,
        MAP_CODE,   // Tile code word from VRAM
        MAP_ATTR,   // Attribute word, next VRAM address
        ROM_RD,     // One 32-bit row slice of 8 pixels
        WRITE_PX,
        DONE
    } fetch_state_e;

    typedef logic [`SCR_PXL_W-1:0] pxl_t;

endpackage

`default_nettype wire

//--- hdl/scroll_defines.svh
// Line buffer geometry and output blanking for the scroll renderer
// One buffer half covers 512 addresses, of which only the first 448 get rendered
`ifndef SCROLL_DEFINES_SVH
`define SCROLL_DEFINES_SVH

// Address width of one buffer half
`define SCR_LINE_W     9

// Active window on hdump, both ends inclusive
`define SCR_ACT_START  9'd64
`define SCR_ACT_END    9'd447

// Pixels written per layer and line, from buffer address 0
`define SCR_RENDER_W   448

`define SCR_PXL_W      11
`define SCR_BLANK      11'h1ff  // Shown outside the window and for disabled layers

`endif
